// File: include/ex_defines.svh
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// datapath and field widths
`define EX_XLEN     64
`define EX_REG_AW   5
`define EX_CSR_AW   12

// major opcodes, inst[6:0]
`define EX_OP_I     7'b0010011
`define EX_OP_IW    7'b0011011
`define EX_OP_R     7'b0110011
`define EX_OP_RW    7'b0111011
`define EX_OP_B     7'b1100011
`define EX_OP_JAL   7'b1101111
`define EX_OP_JALR  7'b1100111
`define EX_OP_LUI   7'b0110111
`define EX_OP_AUIPC 7'b0010111
`define EX_OP_CSR   7'b1110011

// funct3 for alu ops, shared by reg-reg and reg-imm forms
`define EX_F3_ADD   3'b000
`define EX_F3_SLL   3'b001
`define EX_F3_SLT   3'b010
`define EX_F3_SLTU  3'b011
`define EX_F3_XOR   3'b100
`define EX_F3_SR    3'b101
`define EX_F3_OR    3'b110
`define EX_F3_AND   3'b111

// branch funct3
`define EX_F3_BEQ   3'b000
`define EX_F3_BNE   3'b001
`define EX_F3_BLT   3'b100
`define EX_F3_BGE   3'b101
`define EX_F3_BLTU  3'b110
`define EX_F3_BGEU  3'b111

// jalr only defines funct3 000
`define EX_F3_JALR  3'b000

// csr funct3, bit 2 picks the uimm form
`define EX_F3_CSRRW  3'b001
`define EX_F3_CSRRS  3'b010
`define EX_F3_CSRRC  3'b011
`define EX_F3_CSRRWI 3'b101
`define EX_F3_CSRRSI 3'b110
`define EX_F3_CSRRCI 3'b111

// funct7, alt selects sub and arithmetic shift
`define EX_F7_BASE  7'b0000000
`define EX_F7_ALT   7'b0100000

// machine csr addresses held locally
`define EX_CSR_MSTATUS  12'h300
`define EX_CSR_MTVEC    12'h305
`define EX_CSR_MSCRATCH 12'h340
`define EX_CSR_MEPC     12'h341

// number of implemented csrs
`define EX_CSR_NUM  4

`endif

// File: verilog/ex_pkg.sv
`include "ex_defines.svh"

package ex_pkg;

	// r-type view of the instruction word
	typedef struct packed {
		logic [6:0]            funct7;
		logic [`EX_REG_AW-1:0] rs2;
		logic [`EX_REG_AW-1:0] rs1;
		logic [2:0]            funct3;
		logic [`EX_REG_AW-1:0] rd;
		logic [6:0]            opcode;
	} inst_r_t;

	// i-type view, imm12 overlays funct7 and rs2
	typedef struct packed {
		logic [11:0]           imm12;
		logic [`EX_REG_AW-1:0] rs1;
		logic [2:0]            funct3;
		logic [`EX_REG_AW-1:0] rd;
		logic [6:0]            opcode;
	} inst_i_t;

	// same 32 bits, two decodings
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_u;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS1,
		ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} br_cond_e;

	typedef enum logic [2:0] {
		CSR_NONE, CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI
	} csr_cmd_e;

	// one decoded instruction from the decode stage
	typedef struct packed {
		logic                  valid;
		inst_u                 inst;
		logic [`EX_XLEN-1:0]   inst_addr;
		logic [`EX_XLEN-1:0]   op1;
		logic [`EX_XLEN-1:0]   op2;
		logic [`EX_REG_AW-1:0] rd_addr;
		logic [`EX_XLEN-1:0]   base_addr;
		logic [`EX_XLEN-1:0]   addr_offset;
		logic                  csr_we;
		logic [`EX_CSR_AW-1:0] csr_waddr;
	} ex_in_t;

	typedef struct packed {
		alu_op_e  alu_op;
		br_cond_e br_cond;
		csr_cmd_e csr_cmd;
		logic     rd_we;
	} ex_ctrl_t;

	typedef struct packed {
		logic                  rd_wen;
		logic [`EX_REG_AW-1:0] rd_addr;
		logic [`EX_XLEN-1:0]   rd_data;
	} ex_wb_t;

	typedef struct packed {
		logic                en;
		logic [`EX_XLEN-1:0] addr;
	} ex_jump_t;

endpackage

// File: verilog/ex_decode.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_decode
	import ex_pkg::*;
(
	input  inst_u    inst_i,
	input  logic     valid_i,
	output ex_ctrl_t ctrl_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] imm_hi;
	logic       base7;
	logic       alt7;
	logic       shi_base;
	logic       shi_alt;

	assign opcode = inst_i.r.opcode;
	assign funct3 = inst_i.i.funct3;
	assign funct7 = inst_i.r.funct7;
	// rv64 shamt is 6 bits, so only imm[11:6] carries the shift kind
	assign imm_hi = inst_i.i.imm12[11:6];

	assign base7    = (funct7 == `EX_F7_BASE);
	assign alt7     = (funct7 == `EX_F7_ALT);
	assign shi_base = ({imm_hi, 1'b0} == `EX_F7_BASE);
	assign shi_alt  = ({imm_hi, 1'b0} == `EX_F7_ALT);

	always_comb begin
		// default is a bubble: add, no branch, no csr, no write
		ctrl_o = '0;
		if (valid_i) begin
			case (opcode)
				`EX_OP_R: begin
					// alt funct7 only legal for add/sub and srl/sra
					ctrl_o.rd_we = base7 ||
						(alt7 && (funct3 == `EX_F3_ADD || funct3 == `EX_F3_SR));
					case (funct3)
						`EX_F3_ADD:  ctrl_o.alu_op = alt7 ? ALU_SUB : ALU_ADD;
						`EX_F3_SLL:  ctrl_o.alu_op = ALU_SLL;
						`EX_F3_SLT:  ctrl_o.alu_op = ALU_SLT;
						`EX_F3_SLTU: ctrl_o.alu_op = ALU_SLTU;
						`EX_F3_XOR:  ctrl_o.alu_op = ALU_XOR;
						`EX_F3_SR:   ctrl_o.alu_op = alt7 ? ALU_SRA : ALU_SRL;
						`EX_F3_OR:   ctrl_o.alu_op = ALU_OR;
						default:     ctrl_o.alu_op = ALU_AND;
					endcase
				end
				`EX_OP_I: begin
					ctrl_o.rd_we = 1'b1;
					case (funct3)
						`EX_F3_ADD:  ctrl_o.alu_op = ALU_ADD;
						`EX_F3_SLT:  ctrl_o.alu_op = ALU_SLT;
						`EX_F3_SLTU: ctrl_o.alu_op = ALU_SLTU;
						`EX_F3_XOR:  ctrl_o.alu_op = ALU_XOR;
						`EX_F3_OR:   ctrl_o.alu_op = ALU_OR;
						`EX_F3_AND:  ctrl_o.alu_op = ALU_AND;
						`EX_F3_SLL: begin
							ctrl_o.alu_op = ALU_SLL;
							ctrl_o.rd_we  = shi_base;
						end
						default: begin
							ctrl_o.alu_op = shi_alt ? ALU_SRA : ALU_SRL;
							ctrl_o.rd_we  = shi_base || shi_alt;
						end
					endcase
				end
				// word forms, imm and reg share most of the table
				`EX_OP_IW, `EX_OP_RW: begin
					case (funct3)
						`EX_F3_ADD: begin
							ctrl_o.alu_op = (opcode == `EX_OP_RW && alt7) ? ALU_SUBW : ALU_ADDW;
							ctrl_o.rd_we  = (opcode == `EX_OP_IW) || base7 || alt7;
						end
						`EX_F3_SLL: begin
							ctrl_o.alu_op = ALU_SLLW;
							ctrl_o.rd_we  = base7;
						end
						`EX_F3_SR: begin
							ctrl_o.alu_op = alt7 ? ALU_SRAW : ALU_SRLW;
							ctrl_o.rd_we  = base7 || alt7;
						end
						default: ctrl_o.rd_we = 1'b0;
					endcase
				end
				`EX_OP_B: begin
					// branches never write rd
					case (funct3)
						`EX_F3_BEQ:  ctrl_o.br_cond = BR_EQ;
						`EX_F3_BNE:  ctrl_o.br_cond = BR_NE;
						`EX_F3_BLT:  ctrl_o.br_cond = BR_LT;
						`EX_F3_BGE:  ctrl_o.br_cond = BR_GE;
						`EX_F3_BLTU: ctrl_o.br_cond = BR_LTU;
						`EX_F3_BGEU: ctrl_o.br_cond = BR_GEU;
						default:     ctrl_o.br_cond = BR_NONE;
					endcase
				end
				`EX_OP_JAL: begin
					ctrl_o.br_cond = BR_ALWAYS;
					ctrl_o.rd_we   = 1'b1;
				end
				`EX_OP_JALR: begin
					if (funct3 == `EX_F3_JALR) begin
						ctrl_o.br_cond = BR_ALWAYS;
						ctrl_o.rd_we   = 1'b1;
					end
				end
				`EX_OP_LUI: begin
					ctrl_o.alu_op = ALU_PASS1;
					ctrl_o.rd_we  = 1'b1;
				end
				// link value pc + imm arrives pre-split in op1/op2
				`EX_OP_AUIPC: ctrl_o.rd_we = 1'b1;
				`EX_OP_CSR: begin
					ctrl_o.rd_we = 1'b1;
					case (funct3)
						`EX_F3_CSRRW:  ctrl_o.csr_cmd = CSR_RW;
						`EX_F3_CSRRS:  ctrl_o.csr_cmd = CSR_RS;
						`EX_F3_CSRRC:  ctrl_o.csr_cmd = CSR_RC;
						`EX_F3_CSRRWI: ctrl_o.csr_cmd = CSR_RWI;
						`EX_F3_CSRRSI: ctrl_o.csr_cmd = CSR_RSI;
						`EX_F3_CSRRCI: ctrl_o.csr_cmd = CSR_RCI;
						// ecall, ebreak and reserved funct3 do nothing here
						default:       ctrl_o.rd_we   = 1'b0;
					endcase
				end
				default: ctrl_o.rd_we = 1'b0;
			endcase
		end
	end

endmodule

// File: verilog/ex_alu.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_alu
	import ex_pkg::*;
(
	input  alu_op_e             op_i,
	input  logic [`EX_XLEN-1:0] op1_i,
	input  logic [`EX_XLEN-1:0] op2_i,
	output logic [`EX_XLEN-1:0] result_o
);

	logic [`EX_XLEN-1:0] sum;
	logic [`EX_XLEN-1:0] diff;
	logic [5:0]          shamt;
	logic [4:0]          shamt_w;
	logic                lt_s;
	logic                lt_u;
	logic [31:0]         word_res;

	// one adder and one subtractor shared by full and word forms
	assign sum  = op1_i + op2_i;
	assign diff = op1_i - op2_i;

	assign shamt   = op2_i[5:0];
	assign shamt_w = op2_i[4:0];

	assign lt_s = ($signed(op1_i) < $signed(op2_i));
	assign lt_u = (op1_i < op2_i);

	// 32-bit result of the word ops, before sign extension
	always_comb begin
		case (op_i)
			ALU_SUBW: word_res = diff[31:0];
			ALU_SLLW: word_res = op1_i[31:0] << shamt_w;
			ALU_SRLW: word_res = op1_i[31:0] >> shamt_w;
			// sign from bit 31 of op1
			ALU_SRAW: word_res = $signed(op1_i[31:0]) >>> shamt_w;
			default:  word_res = sum[31:0];
		endcase
	end

	always_comb begin
		case (op_i)
			ALU_ADD:   result_o = sum;
			ALU_SUB:   result_o = diff;
			ALU_SLL:   result_o = op1_i << shamt;
			ALU_SLT:   result_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
			ALU_XOR:   result_o = op1_i ^ op2_i;
			ALU_SRL:   result_o = op1_i >> shamt;
			// full width sra fills from bit 63
			ALU_SRA:   result_o = $signed(op1_i) >>> shamt;
			ALU_OR:    result_o = op1_i | op2_i;
			ALU_AND:   result_o = op1_i & op2_i;
			ALU_PASS1: result_o = op1_i;
			ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW:
				result_o = {{(`EX_XLEN-32){word_res[31]}}, word_res};
			default:   result_o = '0;
		endcase
	end

endmodule

// File: verilog/ex_branch.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_branch
	import ex_pkg::*;
(
	input  br_cond_e            cond_i,
	input  logic [`EX_XLEN-1:0] op1_i,
	input  logic [`EX_XLEN-1:0] op2_i,
	input  logic [`EX_XLEN-1:0] base_addr_i,
	input  logic [`EX_XLEN-1:0] addr_offset_i,
	output ex_jump_t            jump_o
);

	logic eq;
	logic lt_s;
	logic lt_u;
	logic take;

	// three comparators cover all six conditions
	assign eq   = (op1_i == op2_i);
	assign lt_s = ($signed(op1_i) < $signed(op2_i));
	assign lt_u = (op1_i < op2_i);

	always_comb begin
		case (cond_i)
			BR_ALWAYS: take = 1'b1;
			BR_EQ:     take = eq;
			BR_NE:     take = !eq;
			BR_LT:     take = lt_s;
			BR_GE:     take = !lt_s;
			BR_LTU:    take = lt_u;
			BR_GEU:    take = !lt_u;
			default:   take = 1'b0;
		endcase
	end

	// target computed for every instruction, en decides
	assign jump_o = '{en: take, addr: base_addr_i + addr_offset_i};

endmodule

// File: verilog/ex_csr_regs.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_csr_regs
	import ex_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  csr_cmd_e              cmd_i,
	input  logic                  we_i,
	input  logic [`EX_CSR_AW-1:0] addr_i,
	input  logic [`EX_XLEN-1:0]   op1_i,
	input  logic [4:0]            uimm_i,
	input  logic                  int_assert_i,
	output logic [`EX_XLEN-1:0]   rdata_o
);

	logic [`EX_XLEN-1:0]            csr_q [`EX_CSR_NUM];
	logic [$clog2(`EX_CSR_NUM)-1:0] idx;
	logic                           hit;
	logic [`EX_XLEN-1:0]            src;
	logic [`EX_XLEN-1:0]            wdata;
	logic                           wen;

	// csr address to storage slot
	always_comb begin
		hit = 1'b1;
		case (addr_i)
			`EX_CSR_MSTATUS:  idx = 0;
			`EX_CSR_MTVEC:    idx = 1;
			`EX_CSR_MSCRATCH: idx = 2;
			`EX_CSR_MEPC:     idx = 3;
			default: begin
				idx = 0;
				hit = 1'b0;
			end
		endcase
	end

	// unmapped addresses read as zero
	assign rdata_o = hit ? csr_q[idx] : '0;

	// immediate forms take the zero-extended rs1 field
	assign src = (cmd_i inside {CSR_RWI, CSR_RSI, CSR_RCI}) ?
		{{(`EX_XLEN-5){1'b0}}, uimm_i} : op1_i;

	always_comb begin
		case (cmd_i)
			CSR_RW, CSR_RWI: wdata = src;
			CSR_RS, CSR_RSI: wdata = rdata_o | src;
			CSR_RC, CSR_RCI: wdata = rdata_o & ~src;
			default:         wdata = rdata_o;
		endcase
	end

	// interrupt kills the write of the instruction it overrides
	assign wen = we_i && (cmd_i != CSR_NONE) && !int_assert_i && hit;

	// same edge as the result register, next instruction sees new value
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int k = 0; k < `EX_CSR_NUM; k++)
				csr_q[k] <= '0;
		end else if (wen) begin
			csr_q[idx] <= wdata;
		end
	end

endmodule

// File: verilog/ex_result_reg.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_result_reg
	import ex_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_i,
	input  logic                  rd_we_i,
	input  logic [`EX_REG_AW-1:0] rd_addr_i,
	input  logic                  is_csr_i,
	input  logic [`EX_XLEN-1:0]   alu_result_i,
	input  logic [`EX_XLEN-1:0]   csr_rdata_i,
	input  ex_jump_t              jump_i,
	input  logic                  int_assert_i,
	input  logic [`EX_XLEN-1:0]   int_addr_i,
	output ex_wb_t                wb_o,
	output ex_jump_t              jump_o
);

	ex_wb_t   wb_d;
	ex_jump_t jump_d;

	always_comb begin
		// csr instructions return the old csr value
		wb_d.rd_data = is_csr_i ? csr_rdata_i : alu_result_i;
		wb_d.rd_addr = rd_addr_i;
		// interrupt wins over any branch and blocks the rd write
		wb_d.rd_wen  = rd_we_i && !int_assert_i;
		jump_d.en    = jump_i.en || int_assert_i;
		jump_d.addr  = int_assert_i ? int_addr_i : jump_i.addr;
	end

	// one cycle toward the memory stage
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_o.rd_wen <= 1'b0;
			jump_o.en   <= 1'b0;
		end else begin
			wb_o   <= wb_d;
			jump_o <= jump_d;
		end
	end

endmodule

// File: verilog/ex_top.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_top
	import ex_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_i,
	input  ex_in_t              in_i,
	input  logic                int_assert_i,
	input  logic [`EX_XLEN-1:0] int_addr_i,
	output ex_wb_t              wb_o,
	output ex_jump_t            jump_o
);

	ex_ctrl_t            ctrl;
	logic [`EX_XLEN-1:0] alu_result;
	logic [`EX_XLEN-1:0] csr_rdata;
	ex_jump_t            br_jump;

	ex_decode u_decode (
		.inst_i  (in_i.inst),
		.valid_i (in_i.valid),
		.ctrl_o  (ctrl)
	);

	ex_alu u_alu (
		.op_i     (ctrl.alu_op),
		.op1_i    (in_i.op1),
		.op2_i    (in_i.op2),
		.result_o (alu_result)
	);

	ex_branch u_branch (
		.cond_i        (ctrl.br_cond),
		.op1_i         (in_i.op1),
		.op2_i         (in_i.op2),
		.base_addr_i   (in_i.base_addr),
		.addr_offset_i (in_i.addr_offset),
		.jump_o        (br_jump)
	);

	// uimm for the immediate csr forms sits in the rs1 field
	ex_csr_regs u_csr_regs (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cmd_i        (ctrl.csr_cmd),
		.we_i         (in_i.csr_we),
		.addr_i       (in_i.csr_waddr),
		.op1_i        (in_i.op1),
		.uimm_i       (in_i.inst.i.rs1),
		.int_assert_i (int_assert_i),
		.rdata_o      (csr_rdata)
	);

	ex_result_reg u_result_reg (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.rd_we_i      (ctrl.rd_we),
		.rd_addr_i    (in_i.rd_addr),
		.is_csr_i     (ctrl.csr_cmd != CSR_NONE),
		.alu_result_i (alu_result),
		.csr_rdata_i  (csr_rdata),
		.jump_i       (br_jump),
		.int_assert_i (int_assert_i),
		.int_addr_i   (int_addr_i),
		.wb_o         (wb_o),
		.jump_o       (jump_o)
	);

endmodule

// File: sim/ex_sva.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module ex_sva
	import ex_pkg::*;
(
	input logic                clk_i,
	input logic                rst_i,
	input logic                int_assert_i,
	input logic [`EX_XLEN-1:0] int_addr_i,
	input ex_wb_t              wb_i,
	input ex_jump_t            jump_i
);

	// number of assertion failures so far
	int fail_count = 0;

	// reset edge clears the write enable and the redirect
	reset_clears: assert property (@(posedge clk_i)
		rst_i |=> (!wb_i.rd_wen && !jump_i.en))
		else begin
			$error("rd_wen or jump en set one cycle after reset");
			fail_count++;
		end

	// interrupt redirects to its own address and kills the rd write
	int_redirect: assert property (@(posedge clk_i) disable iff (rst_i)
		int_assert_i |=> (jump_i.en && jump_i.addr == $past(int_addr_i) && !wb_i.rd_wen))
		else begin
			$error("interrupt override not applied on the next cycle");
			fail_count++;
		end

	// first edge after reset still shows the unreset data fields
	wb_known: assert property (@(posedge clk_i) disable iff (rst_i)
		!$past(rst_i) |-> !$isunknown(wb_i))
		else begin
			$error("write-back struct has unknown bits");
			fail_count++;
		end

endmodule

bind ex_top ex_sva u_sva (
	.clk_i        (clk_i),
	.rst_i        (rst_i),
	.int_assert_i (int_assert_i),
	.int_addr_i   (int_addr_i),
	.wb_i         (wb_o),
	.jump_i       (jump_o)
);

// File: sim/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD     = 8,
	parameter int RST_CYCLES = 10
) (
	output logic clk_o,
	output logic rst_o
);

	// free running clock, starts low
	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// reset high for a fixed count of rising edges, then released on an edge
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

// File: sim/tb_ex.sv
`timescale 1ns/10ps
`include "ex_defines.svh"

module tb_ex
	import ex_pkg::*;
();

	localparam int    CLK_PERIOD    = 8;
	localparam int    RST_CYCLES    = 10;
	localparam int    MARGIN_CYCLES = 100;
	localparam string STIM_FILE     = "sim/ex_stim.txt";

	// dut inputs of one stim line followed by its expected outputs
	typedef struct packed {
		ex_in_t              drv;
		logic                int_assert;
		logic [`EX_XLEN-1:0] int_addr;
		ex_wb_t              exp_wb;
		ex_jump_t            exp_jump;
	} vec_t;

	logic                clk;
	logic                rst;
	ex_in_t              dut_in;
	logic                int_assert;
	logic [`EX_XLEN-1:0] int_addr;
	ex_wb_t              wb;
	ex_jump_t            jump;

	vec_t vecs[$];
	int   errors = 0;
	bit   load_done;

	tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clock (
		.clk_o (clk),
		.rst_o (rst)
	);

	ex_top u_dut (
		.clk_i        (clk),
		.rst_i        (rst),
		.in_i         (dut_in),
		.int_assert_i (int_assert),
		.int_addr_i   (int_addr),
		.wb_o         (wb),
		.jump_o       (jump)
	);

	task automatic check_value(input string name, input logic [`EX_XLEN-1:0] got,
			input logic [`EX_XLEN-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic load_vectors();
		int                  fd;
		int                  rc;
		string               line;
		logic [`EX_XLEN-1:0] fld [16];
		vec_t                v;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("could not open stimulus file %s", STIM_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				// blank and comment lines carry no vector
				if (rc > 0 && line.len() > 1 && line[0] != "#") begin
					rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
						fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15]);
					if (rc != 16) begin
						errors++;
						$display("stimulus line has %0d fields instead of 16: %s", rc, line);
					end else begin
						v = '0;
						v.drv.valid       = fld[0][0];
						v.drv.inst        = fld[1][31:0];
						v.drv.op1         = fld[2];
						v.drv.op2         = fld[3];
						v.drv.rd_addr     = fld[4][`EX_REG_AW-1:0];
						// pc of a branch is also its base
						v.drv.inst_addr   = fld[5];
						v.drv.base_addr   = fld[5];
						v.drv.addr_offset = fld[6];
						v.drv.csr_we      = fld[7][0];
						v.drv.csr_waddr   = fld[8][`EX_CSR_AW-1:0];
						v.int_assert      = fld[9][0];
						v.int_addr        = fld[10];
						v.exp_wb.rd_wen   = fld[11][0];
						v.exp_wb.rd_addr  = fld[12][`EX_REG_AW-1:0];
						v.exp_wb.rd_data  = fld[13];
						v.exp_jump.en     = fld[14][0];
						v.exp_jump.addr   = fld[15];
						vecs.push_back(v);
					end
				end
			end
			$fclose(fd);
			if (vecs.size() == 0) begin
				errors++;
				$display("stimulus file holds no vectors");
			end
		end
	endtask

	task automatic drive_vector(input vec_t v);
		vec_t d;
		d = v;
		// operand fields of an idle slot are junk the stage must ignore
		if (!d.drv.valid) begin
			d.drv.inst_addr   = {$urandom, $urandom};
			d.drv.op1         = {$urandom, $urandom};
			d.drv.op2         = {$urandom, $urandom};
			d.drv.base_addr   = {$urandom, $urandom};
			d.drv.addr_offset = {$urandom, $urandom};
			d.drv.rd_addr     = 5'($urandom);
		end
		dut_in     <= d.drv;
		int_assert <= d.int_assert;
		int_addr   <= d.int_addr;
	endtask

	// data and target only matter when the enables are set
	task automatic compare_outputs(input vec_t v);
		check_value("wb_o.rd_wen", wb.rd_wen, v.exp_wb.rd_wen);
		if (v.exp_wb.rd_wen) begin
			check_value("wb_o.rd_addr", wb.rd_addr, v.exp_wb.rd_addr);
			check_value("wb_o.rd_data", wb.rd_data, v.exp_wb.rd_data);
		end
		check_value("jump_o.en", jump.en, v.exp_jump.en);
		if (v.exp_jump.en)
			check_value("jump_o.addr", jump.addr, v.exp_jump.addr);
	endtask

	initial begin
		dut_in     = '0;
		int_assert = 1'b0;
		int_addr   = '0;
		void'($urandom(32'hd65c_b962));
		load_vectors();
		load_done = 1'b1;
		@(posedge clk);
		while (rst)
			@(posedge clk);
		// vector i goes in on one edge and is checked after the next one
		for (int i = 0; i <= vecs.size(); i++) begin
			if (i > 0)
				@(posedge clk);
			if (i < vecs.size())
				drive_vector(vecs[i]);
			else
				drive_vector('0);
			@(negedge clk);
			if (i > 0)
				compare_outputs(vecs[i-1]);
		end
		$display("%0d vectors, %0d check errors, %0d assertion failures",
			vecs.size(), errors, u_dut.u_sva.fail_count);
		if (errors == 0 && u_dut.u_sva.fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// limit scales with the vector count
	initial begin
		wait (load_done);
		#((vecs.size() + RST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("watchdog timeout at %0d ns, stimulus did not complete", $time);
		$display("%0d vectors, %0d check errors, %0d assertion failures",
			vecs.size(), errors, u_dut.u_sva.fail_count);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: sim/ex_stim.txt
# valid inst op1 op2 rd base offset csr_we csr_addr int int_addr (inputs, hex)
# then rd_wen rd_addr rd_data jump_en jump_addr (expected, hex)
1 00000033 5 7 01 0 0 0 000 0 0 1 01 c 0 0
1 40000033 3 5 02 0 0 0 000 0 0 1 02 fffffffffffffffe 0 0
1 00001033 1 43 03 0 0 0 000 0 0 1 03 8 0 0
1 00005033 8000000000000000 3f 04 0 0 0 000 0 0 1 04 1 0 0
1 40005033 8000000000000000 4 05 0 0 0 000 0 0 1 05 f800000000000000 0 0
1 4000503b 80000000 4 06 0 0 0 000 0 0 1 06 fffffffff8000000 0 0
1 4000503b 8000000000000000 4 07 0 0 0 000 0 0 1 07 0 0 0
1 00002033 ffffffffffffffff 1 08 0 0 0 000 0 0 1 08 1 0 0
1 00003033 ffffffffffffffff 1 09 0 0 0 000 0 0 1 09 0 0 0
1 0000003b 7fffffff 1 0a 0 0 0 000 0 0 1 0a ffffffff80000000 0 0
1 4000003b 0 1 0b 0 0 0 000 0 0 1 0b ffffffffffffffff 0 0
1 0000103b 1 3f 0c 0 0 0 000 0 0 1 0c ffffffff80000000 0 0
1 40005013 8000000000000000 3c 0f 0 0 0 000 0 0 1 0f fffffffffffffff8 0 0
1 00000063 5 5 1f 1000 20 0 000 0 0 0 00 0 1 1020
1 00000063 5 6 1f 1000 20 0 000 0 0 0 00 0 0 0
1 00001063 5 6 1f 1000 20 0 000 0 0 0 00 0 1 1020
1 00001063 5 5 1f 1000 20 0 000 0 0 0 00 0 0 0
1 00004063 ffffffffffffffff 1 1f 1000 20 0 000 0 0 0 00 0 1 1020
1 00004063 1 ffffffffffffffff 1f 1000 20 0 000 0 0 0 00 0 0 0
1 00005063 1 ffffffffffffffff 1f 1000 20 0 000 0 0 0 00 0 1 1020
1 00005063 ffffffffffffffff 1 1f 1000 20 0 000 0 0 0 00 0 0 0
1 00006063 1 ffffffffffffffff 1f 1000 20 0 000 0 0 0 00 0 1 1020
1 00006063 ffffffffffffffff 1 1f 1000 20 0 000 0 0 0 00 0 0 0
1 00007063 ffffffffffffffff 1 1f 1000 20 0 000 0 0 0 00 0 1 1020
1 00007063 1 ffffffffffffffff 1f 1000 20 0 000 0 0 0 00 0 0 0
1 0000006f 1000 4 01 1000 100 0 000 0 0 1 01 1004 1 1100
1 00000067 2000 4 01 3000 8 0 000 0 0 1 01 2004 1 3008
1 00000037 12345000 99 02 0 0 0 000 0 0 1 02 12345000 0 0
1 00000017 1000 12345000 03 0 0 0 000 0 0 1 03 12346000 0 0
1 34001073 a5a5 0 04 0 0 1 340 0 0 1 04 0 0 0
1 34002073 f00 0 05 0 0 1 340 0 0 1 05 a5a5 0 0
1 3402f073 0 0 06 0 0 1 340 0 0 1 06 afa5 0 0
1 34002073 0 0 07 0 0 1 340 0 0 1 07 afa0 0 0
1 7c002073 ffff 0 08 0 0 1 7c0 0 0 1 08 0 0 0
1 00000033 1 2 09 0 0 0 000 1 8000 0 00 0 1 8000
1 34001073 dead 0 0a 0 0 1 340 1 8004 0 00 0 1 8004
1 34002073 0 0 0b 0 0 1 340 0 0 1 0b afa0 0 0
0 00000033 0 0 00 0 0 0 000 1 8008 0 00 0 1 8008
1 0000007f 5 7 0c 0 0 0 000 0 0 0 00 0 0 0
1 02000033 5 7 0d 0 0 0 000 0 0 0 00 0 0 0
1 00002063 5 5 0e 1000 20 0 000 0 0 0 00 0 0 0
1 00001067 2000 4 0e 3000 8 0 000 0 0 0 00 0 0 0
0 00000033 0 0 00 0 0 0 000 0 0 0 00 0 0 0

// File: project.f
+incdir+include
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_csr_regs.sv
verilog/ex_result_reg.sv
verilog/ex_top.sv
sim/ex_sva.sv
sim/tb_clock.sv
sim/tb_ex.sv
